// ==== rtl/led_panel_params.svh ====
`ifndef LED_PANEL_PARAMS_SVH
`define LED_PANEL_PARAMS_SVH

// serial driver chains, one bit per chain in each framebuffer word
`define NUM_CHAINS 30

// shift bits loaded per column
`define COLUMN_BITS 8

// multiplexed panel columns
`define NUM_COLUMNS 8

// input buffer entries and the source's starting credit count
`define FIFO_DEPTH 4

// system clocks per controller enable tick
`define CLK_DIV 4

// enable ticks with gclk held off after the latch
`define BLANKING_TIME 6

// system clocks per heartbeat toggle
`define HB_COUNT 40

`endif

// ==== rtl/led_panel_pkg.sv ====
`include "led_panel_params.svh"

package led_panel_pkg;

    // one bit for each driver chain
    typedef logic [`NUM_CHAINS-1:0] fb_word_t;

    // one-hot active column
    typedef logic [`NUM_COLUMNS-1:0] column_sel_t;

    // shift bit position within a column load
    typedef logic [$clog2(`COLUMN_BITS+1)-1:0] bit_count_t;

    // blanking ticks elapsed
    typedef logic [$clog2(`BLANKING_TIME+1)-1:0] blank_count_t;

    // driver controller FSM
    typedef enum logic [2:0] {
        IDLE,
        SHIFT_LOW,
        SHIFT_HIGH,
        LATCH,
        BLANK
    } drv_state_t;

endpackage

// ==== rtl/clock_enable.sv ====
`timescale 1ns/1ps
`include "led_panel_params.svh"

module clock_enable (
    input  logic clk,
    input  logic arst_n,
    output logic en_tick
);

    typedef logic [$clog2(`CLK_DIV)-1:0] div_count_t;

    div_count_t div_cnt;

    // strobe on the last count of each period
    assign en_tick = (div_cnt == div_count_t'(`CLK_DIV - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (en_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/word_fifo.sv ====
`timescale 1ns/1ps
`include "led_panel_params.svh"

module word_fifo import led_panel_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  fb_word_t push_data,
    input  logic     pop,
    output fb_word_t head_data,
    output logic     empty,
    output logic     credit_return
);

    typedef logic [$clog2(`FIFO_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] occ_t;

    fb_word_t mem [`FIFO_DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    occ_t     count;
    logic     do_pop;

    assign empty     = (count == '0);
    assign head_data = mem[rd_ptr];
    assign do_pop    = pop && !empty;

    // every word leaving hands one credit back upstream
    assign credit_return = do_pop;

    // storage written on every push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/driver_controller.sv ====
`timescale 1ns/1ps
`include "led_panel_params.svh"

module driver_controller import led_panel_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     en_tick,
    input  logic     fifo_empty,
    input  fb_word_t fifo_data,
    output logic     fifo_pop,
    output logic     driver_sclk,
    output logic     driver_gclk,
    output logic     driver_lat,
    output fb_word_t drivers_sin,
    output logic     column_ready
);

    drv_state_t   state;
    bit_count_t   bit_cnt;
    blank_count_t blank_cnt;
    logic         load_slot;
    logic         last_bit;
    logic         last_blank;

    assign load_slot  = (state == IDLE) || (state == SHIFT_LOW);
    assign last_bit   = (bit_cnt == bit_count_t'(`COLUMN_BITS - 1));
    assign last_blank = (blank_cnt == blank_count_t'(`BLANKING_TIME - 1));

    // read the head word only on a tick in a load slot
    assign fifo_pop = en_tick && load_slot && !fifo_empty;

    // chain data set up half a shift period before sclk rises
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            drivers_sin <= fifo_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= IDLE;
            bit_cnt      <= '0;
            blank_cnt    <= '0;
            driver_sclk  <= 1'b0;
            driver_gclk  <= 1'b0;
            driver_lat   <= 1'b0;
            column_ready <= 1'b0;
        end else begin
            column_ready <= 1'b0;
            if (en_tick) begin
                case (state)
                    IDLE, SHIFT_LOW: begin
                        driver_sclk <= 1'b0;
                        driver_gclk <= ~driver_gclk;
                        // without a word we just sit here with sclk low
                        if (!fifo_empty) begin
                            state <= SHIFT_HIGH;
                        end
                    end
                    SHIFT_HIGH: begin
                        driver_sclk <= 1'b1;
                        driver_gclk <= ~driver_gclk;
                        if (last_bit) begin
                            bit_cnt <= '0;
                            state   <= LATCH;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state   <= SHIFT_LOW;
                        end
                    end
                    LATCH: begin
                        // sclk drops on the same edge lat rises
                        driver_sclk <= 1'b0;
                        driver_lat  <= 1'b1;
                        driver_gclk <= 1'b0;
                        blank_cnt   <= '0;
                        state       <= BLANK;
                    end
                    BLANK: begin
                        driver_lat  <= 1'b0;
                        driver_gclk <= 1'b0;
                        if (last_blank) begin
                            column_ready <= 1'b1;
                            state        <= SHIFT_LOW;
                        end else begin
                            blank_cnt <= blank_cnt + 1'b1;
                        end
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/column_mux.sv ====
`timescale 1ns/1ps
`include "led_panel_params.svh"

module column_mux import led_panel_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        column_ready,
    output column_sel_t mux_out
);

    // starts at column 0 and rotates left with wrap on each advance strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mux_out <= column_sel_t'(1);
        end else if (column_ready) begin
            mux_out <= {mux_out[`NUM_COLUMNS-2:0], mux_out[`NUM_COLUMNS-1]};
        end
    end

endmodule

// ==== rtl/heartbeat.sv ====
`timescale 1ns/1ps
`include "led_panel_params.svh"

module heartbeat (
    input  logic clk,
    input  logic arst_n,
    output logic heartbeat_led
);

    typedef logic [$clog2(`HB_COUNT)-1:0] hb_count_t;

    hb_count_t hb_cnt;
    logic      wrap;

    assign wrap = (hb_cnt == hb_count_t'(`HB_COUNT - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hb_cnt        <= '0;
            heartbeat_led <= 1'b0;
        end else if (wrap) begin
            hb_cnt        <= '0;
            heartbeat_led <= ~heartbeat_led;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/led_panel_top.sv ====
`timescale 1ns/1ps

module led_panel_top import led_panel_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pix_valid,
    input  fb_word_t    pix_data,
    output logic        credit_return,
    output logic        driver_sclk,
    output logic        driver_gclk,
    output logic        driver_lat,
    output fb_word_t    drivers_sin,
    output column_sel_t mux_out,
    output logic        heartbeat_led
);

    logic     en_tick;
    logic     fifo_empty;
    fb_word_t fifo_data;
    logic     fifo_pop;
    logic     column_ready;

    // framebuffer words in, credits back to the source
    word_fifo u_word_fifo (
        .clk           (clk),
        .arst_n        (arst_n),
        .push          (pix_valid),
        .push_data     (pix_data),
        .pop           (fifo_pop),
        .head_data     (fifo_data),
        .empty         (fifo_empty),
        .credit_return (credit_return)
    );

    // shift pacing for the controller
    clock_enable u_clock_enable (
        .clk     (clk),
        .arst_n  (arst_n),
        .en_tick (en_tick)
    );

    driver_controller u_driver_controller (
        .clk          (clk),
        .arst_n       (arst_n),
        .en_tick      (en_tick),
        .fifo_empty   (fifo_empty),
        .fifo_data    (fifo_data),
        .fifo_pop     (fifo_pop),
        .driver_sclk  (driver_sclk),
        .driver_gclk  (driver_gclk),
        .driver_lat   (driver_lat),
        .drivers_sin  (drivers_sin),
        .column_ready (column_ready)
    );

    column_mux u_column_mux (
        .clk          (clk),
        .arst_n       (arst_n),
        .column_ready (column_ready),
        .mux_out      (mux_out)
    );

    heartbeat u_heartbeat (
        .clk           (clk),
        .arst_n        (arst_n),
        .heartbeat_led (heartbeat_led)
    );

endmodule

// ==== tests/led_panel_checker.sv ====
`timescale 1ns/1ps

module led_panel_checker import led_panel_pkg::*; (
    input logic        clk,
    input logic        arst_n,
    input logic        credit_return,
    input logic        fifo_empty,
    input logic        driver_lat,
    input logic        driver_sclk,
    input logic        column_ready,
    input column_sel_t mux_out
);

    // latch only while the shift clock is parked low
    lat_without_sclk: assert property (@(posedge clk) disable iff (!arst_n)
        !(driver_lat && driver_sclk))
        else $error("driver_lat and driver_sclk high together");

    credit_needs_word: assert property (@(posedge clk) disable iff (!arst_n)
        credit_return |-> !fifo_empty)
        else $error("credit_return while the FIFO is empty");

    column_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot(mux_out))
        else $error("mux_out is not one-hot");

    ready_single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        column_ready |=> !column_ready)
        else $error("column_ready held longer than one clock");

endmodule

bind led_panel_top led_panel_checker u_checker (
    .clk           (clk),
    .arst_n        (arst_n),
    .credit_return (credit_return),
    .fifo_empty    (fifo_empty),
    .driver_lat    (driver_lat),
    .driver_sclk   (driver_sclk),
    .column_ready  (column_ready),
    .mux_out       (mux_out)
);

// ==== tests/led_panel_tb.sv ====
`timescale 1ns/1ps
`include "led_panel_params.svh"

module led_panel_tb import led_panel_pkg::*; ();

    localparam int NUM_WORDS = 24;
    localparam int CREDIT_TIMEOUT = 400;
    localparam int DONE_TIMEOUT = 3000;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        pix_valid = 1'b0;
    fb_word_t    pix_data = '0;
    logic        credit_return;
    logic        driver_sclk;
    logic        driver_gclk;
    logic        driver_lat;
    fb_word_t    drivers_sin;
    column_sel_t mux_out;
    logic        heartbeat_led;

    fb_word_t    cases [NUM_WORDS];
    logic [15:0] lfsr_state = 16'd48;
    int          errors = 0;
    int          timeouts = 0;
    int          words_sent = 0;
    int          credits_back = 0;
    int          word_idx = 0;
    int          sclk_in_column = 0;
    int          gclk_rises = 0;
    int          columns_done = 0;
    int          hb_toggles = 0;
    int          cycle = 0;
    int          last_hb_cycle = -1;
    int          exp_col_idx = 0;
    logic        blanking = 1'b0;
    column_sel_t exp_col = column_sel_t'(1);
    logic        prev_sclk = 1'b0;
    logic        prev_gclk = 1'b0;
    logic        prev_lat = 1'b0;
    logic        prev_hb = 1'b0;
    column_sel_t prev_mux = column_sel_t'(1);

    led_panel_top DUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .pix_valid     (pix_valid),
        .pix_data      (pix_data),
        .credit_return (credit_return),
        .driver_sclk   (driver_sclk),
        .driver_gclk   (driver_gclk),
        .driver_lat    (driver_lat),
        .drivers_sin   (drivers_sin),
        .mux_out       (mux_out),
        .heartbeat_led (heartbeat_led)
    );

    always #4 clk = ~clk;

    // galois form with taps 16 14 13 11
    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic take_gap(output int gap);
        gap = 0;
        repeat (3) begin
            gap = gap * 2 + int'(lfsr_state[0]);
            lfsr_state = next_lfsr(lfsr_state);
        end
    endtask

    task automatic check_word(input string name, input fb_word_t expected, input fb_word_t actual);
        if (actual !== expected) begin
            $display("ERROR %0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_column(input string name, input column_sel_t expected,
                                input column_sel_t actual);
        if (actual !== expected) begin
            $display("ERROR %0t %s expected %b got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %0t %s expected %b got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR %0t %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // outputs sampled mid-cycle and compared with the previous sample to find edges
    always @(negedge clk) begin
        if (arst_n) begin
            cycle++;
            if (credit_return) begin
                credits_back++;
            end
            if (credits_back > words_sent) begin
                $display("%0t: credit_return pulsed with no word outstanding", $time);
                errors++;
            end
            if (driver_sclk && !prev_sclk) begin
                if (word_idx < NUM_WORDS) begin
                    check_word("drivers_sin", cases[word_idx], drivers_sin);
                end else begin
                    $display("%0t: driver_sclk rose after all words were shifted", $time);
                    errors++;
                end
                word_idx++;
                sclk_in_column++;
            end
            if (driver_lat && !prev_lat) begin
                check_count("sclk edges before driver_lat", `COLUMN_BITS, sclk_in_column);
                if (gclk_rises == 0) begin
                    $display("%0t: driver_gclk never toggled while the column shifted", $time);
                    errors++;
                end
                sclk_in_column = 0;
                exp_col_idx = (exp_col_idx + 1) % `NUM_COLUMNS;
                exp_col = column_sel_t'(1) << exp_col_idx;
                blanking = 1'b1;
            end
            if (mux_out != prev_mux) begin
                check_column("mux_out", exp_col, mux_out);
                blanking = 1'b0;
                gclk_rises = 0;
                columns_done++;
            end
            if (driver_gclk && !prev_gclk) begin
                if (blanking) begin
                    $display("%0t: driver_gclk rose during blanking", $time);
                    errors++;
                end else begin
                    gclk_rises++;
                end
            end
            if (heartbeat_led != prev_hb) begin
                if (last_hb_cycle >= 0) begin
                    check_count("heartbeat_led period", `HB_COUNT, cycle - last_hb_cycle);
                end
                last_hb_cycle = cycle;
                hb_toggles++;
            end
        end
        prev_sclk = driver_sclk;
        prev_gclk = driver_gclk;
        prev_lat = driver_lat;
        prev_hb = heartbeat_led;
        prev_mux = mux_out;
    end

    initial begin
        int gap;
        int waited;
        $readmemh("tests/led_panel_cases.txt", cases);
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_bit("driver_sclk", 1'b0, driver_sclk);
        check_bit("driver_gclk", 1'b0, driver_gclk);
        check_bit("driver_lat", 1'b0, driver_lat);
        check_bit("credit_return", 1'b0, credit_return);
        check_bit("heartbeat_led", 1'b0, heartbeat_led);
        check_column("mux_out", column_sel_t'(1), mux_out);
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;

        // source spends one credit per word and idles between words
        for (int i = 0; i < NUM_WORDS && timeouts == 0; i++) begin
            take_gap(gap);
            repeat (gap) begin
                @(posedge clk);
                #1 pix_valid = 1'b0;
            end
            waited = 0;
            while (words_sent - credits_back >= `FIFO_DEPTH && timeouts == 0) begin
                @(posedge clk);
                #1 pix_valid = 1'b0;
                waited++;
                if (waited > CREDIT_TIMEOUT) begin
                    $display("timed out waiting for a credit before word %0d", i);
                    timeouts++;
                end
            end
            if (timeouts == 0) begin
                @(posedge clk);
                #1;
                pix_valid = 1'b1;
                pix_data = cases[i];
                words_sent++;
            end
        end
        @(posedge clk);
        #1 pix_valid = 1'b0;

        waited = 0;
        while (columns_done < NUM_WORDS / `COLUMN_BITS && timeouts == 0) begin
            @(posedge clk);
            waited++;
            if (waited > DONE_TIMEOUT) begin
                $display("timed out waiting for all columns to latch and advance");
                timeouts++;
            end
        end
        if (timeouts == 0) begin
            check_count("sclk rising edges", NUM_WORDS, word_idx);
            check_count("credit_return pulses", NUM_WORDS, credits_back);
            check_column("mux_out", column_sel_t'(1) << (NUM_WORDS / `COLUMN_BITS), mux_out);
            if (hb_toggles < 2) begin
                $display("heartbeat_led toggled fewer than two times");
                errors++;
            end
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/led_panel_cases.txt ====
// one 30-bit framebuffer word per line in shift order, bit n goes to chain n
3A5C0F12
15E3B7A9
2F0F0F0F
10F0F0F0
3FFFFFFF
00000000
2AAAAAAA
15555555
01234567
389ABCDE
1F00FF00
20FF00FF
3C3C3C3C
03C3C3C3
12345678
2DCBA987
00000001
20000000
1B6DB6DB
24924924
3E1F0F87
01E0F078
2468ACE0
13579BDF

// ==== vlog.f ====
+incdir+rtl
rtl/led_panel_pkg.sv
rtl/clock_enable.sv
rtl/word_fifo.sv
rtl/driver_controller.sv
rtl/column_mux.sv
rtl/heartbeat.sv
rtl/led_panel_top.sv
tests/led_panel_checker.sv
tests/led_panel_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
    --top-module led_panel_tb -o led_panel_sim \
    && ./obj_dir/led_panel_sim | tee /dev/stderr | grep -F "RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
